// File: Makefile
TOP := tb_ecc_sram_top

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --assert --top-module $(TOP) -f flist.f -Mdir obj_dir -o sim_tb

run: build
	./obj_dir/sim_tb | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

lint:
	verilator --lint-only --timing --assert --top-module $(TOP) -f flist.f

clean:
	rm -rf obj_dir sim.log

// File: flist.f
+incdir+include
rtl/ecc_sram_pkg.sv
rtl/secded_39_32_enc.sv
rtl/secded_39_32_dec.sv
rtl/ecc_sram_bank.sv
rtl/ecc_manager_regs.sv
rtl/ecc_sram_wrap.sv
rtl/ecc_sram_top.sv
sim/tb_ecc_sram_top.sv

// File: include/ecc_sram_config.svh
`ifndef ECC_SRAM_CONFIG_SVH
`define ECC_SRAM_CONFIG_SVH

// Bank geometry in 39-bit codewords
`define ECC_BANK_WORDS 256
`define ECC_BANK_AW    $clog2(`ECC_BANK_WORDS)

// APB register map of the ECC manager
`define ECC_REG_CORR   12'h000
`define ECC_REG_UNCORR 12'h004
`define ECC_REG_INJECT 12'h008

`endif

// File: rtl/ecc_manager_regs.sv
`timescale 1ns/10ps
`include "ecc_sram_config.svh"

module ecc_manager_regs import ecc_sram_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  apb_req_t    apb_req_i,
  output apb_rsp_t    apb_rsp_o,
  input  ecc_err_t    err_i,
  input  logic        inject_done_i,
  output ecc_inject_t inject_o,
  output logic        inject_valid_o
);

  ecc_reg_e         reg_sel;
  logic             access;
  logic             reg_write;
  logic [1:0]       cnt_inc;
  logic [1:0]       cnt_clr;
  logic [1:0][31:0] cnt_q;    // [0] correctable, [1] uncorrectable
  ecc_inject_t      inject_q;

  always_comb begin
    case (apb_req_i.paddr)
      `ECC_REG_CORR:   reg_sel = REG_CORR;
      `ECC_REG_UNCORR: reg_sel = REG_UNCORR;
      `ECC_REG_INJECT: reg_sel = REG_INJECT;
      default:         reg_sel = REG_NONE;
    endcase
  end

  assign access    = apb_req_i.psel & apb_req_i.penable;
  assign reg_write = access & apb_req_i.pwrite;

  assign cnt_inc = {err_i.double_err, err_i.single_err};
  assign cnt_clr = {reg_write && (reg_sel == REG_UNCORR),
                    reg_write && (reg_sel == REG_CORR)};

  // Saturating counters, a write of any value clears
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (cnt_clr[i]) begin
          cnt_q[i] <= '0;
        end else if (cnt_inc[i] && (cnt_q[i] != '1)) begin
          cnt_q[i] <= cnt_q[i] + 32'd1;
        end
      end
    end
  end

  // One-shot injection, enables drop once the wrapper has used them
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      inject_q <= '0;
    end else if (reg_write && (reg_sel == REG_INJECT)) begin
      inject_q.pos_a <= apb_req_i.pwdata[5:0];
      inject_q.en_a  <= apb_req_i.pwdata[6];
      inject_q.pos_b <= apb_req_i.pwdata[13:8];
      inject_q.en_b  <= apb_req_i.pwdata[14];
    end else if (inject_done_i) begin
      inject_q.en_a <= 1'b0;
      inject_q.en_b <= 1'b0;
    end
  end

  assign inject_o       = inject_q;
  assign inject_valid_o = inject_q.en_a | inject_q.en_b;

  always_comb begin
    case (reg_sel)
      REG_CORR:   apb_rsp_o.prdata = cnt_q[0];
      REG_UNCORR: apb_rsp_o.prdata = cnt_q[1];
      REG_INJECT: apb_rsp_o.prdata = {17'b0, inject_q.en_b, inject_q.pos_b,
                                      1'b0, inject_q.en_a, inject_q.pos_a};
      default:    apb_rsp_o.prdata = '0;
    endcase
  end

  assign apb_rsp_o.pready  = 1'b1;  // Zero wait states
  assign apb_rsp_o.pslverr = access && (reg_sel == REG_NONE);

  a_apb_penable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    apb_req_i.penable |-> apb_req_i.psel);

endmodule

// File: rtl/ecc_sram_bank.sv
`timescale 1ns/10ps
`include "ecc_sram_config.svh"

module ecc_sram_bank import ecc_sram_pkg::*; (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    req_i,
  input  logic                    we_i,
  input  logic [`ECC_BANK_AW-1:0] addr_i,
  input  codeword_t               wdata_i,
  output codeword_t               rdata_o
);

  // Zero fill is a valid codeword for zero data
  codeword_t mem_q [`ECC_BANK_WORDS] = '{default: '0};
  codeword_t rdata_q;

  always_ff @(posedge clk_i) begin
    if (req_i && we_i) begin
      mem_q[addr_i] <= wdata_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (req_i && !we_i) begin
      rdata_q <= mem_q[addr_i];  // One cycle read latency
    end
  end

  assign rdata_o = rdata_q;

  a_addr_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i |-> !$isunknown(addr_i));

endmodule

// File: rtl/ecc_sram_pkg.sv
package ecc_sram_pkg;

  typedef logic [31:0] data_t;
  typedef logic [38:0] codeword_t;  // Check bits [38:32] above data [31:0]

  typedef struct packed {
    logic        req;
    logic        we;     // 1 for a store
    logic [31:0] addr;   // Byte address
    data_t       wdata;
    logic [3:0]  be;
  } tcdm_req_t;

  typedef struct packed {
    logic  gnt;
    data_t rdata;
  } tcdm_rsp_t;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic single_err;
    logic double_err;
  } ecc_err_t;

  typedef struct packed {
    logic [5:0] pos_a;
    logic       en_a;
    logic [5:0] pos_b;
    logic       en_b;
  } ecc_inject_t;

  typedef enum logic {NORMAL, LOAD_AND_STORE} store_state_e;

  typedef enum logic [1:0] {REG_CORR, REG_UNCORR, REG_INJECT, REG_NONE} ecc_reg_e;

  // One H-matrix column per data bit
  typedef logic [31:0][6:0] hsiao_cols_t;

  // Hsiao columns are the first 32 distinct weight-3 patterns of 7 bits
  function automatic hsiao_cols_t hsiao_columns();
    hsiao_cols_t cols;
    int unsigned n;
    cols = '0;
    n    = 0;
    for (int unsigned v = 0; v < 128; v++) begin
      if ($countones(v[6:0]) == 3 && n < 32) begin
        cols[n] = v[6:0];
        n++;
      end
    end
    return cols;
  endfunction

endpackage

// File: rtl/ecc_sram_top.sv
`timescale 1ns/10ps

module ecc_sram_top import ecc_sram_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  tcdm_req_t tcdm_req_i,
  output tcdm_rsp_t tcdm_rsp_o,
  input  apb_req_t  apb_req_i,
  output apb_rsp_t  apb_rsp_o
);

  // Core port and register port share one protected bank
  ecc_sram_wrap i_wrap (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .tcdm_req_i (tcdm_req_i),
    .tcdm_rsp_o (tcdm_rsp_o),
    .apb_req_i  (apb_req_i),
    .apb_rsp_o  (apb_rsp_o)
  );

endmodule

// File: rtl/ecc_sram_wrap.sv
`timescale 1ns/10ps
`include "ecc_sram_config.svh"

module ecc_sram_wrap import ecc_sram_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  tcdm_req_t tcdm_req_i,
  output tcdm_rsp_t tcdm_rsp_o,
  input  apb_req_t  apb_req_i,
  output apb_rsp_t  apb_rsp_o
);

  store_state_e            state_d, state_q;
  logic [`ECC_BANK_AW-1:0] req_word;
  logic [`ECC_BANK_AW-1:0] addr_q;
  data_t                   wdata_q;
  logic [3:0]              be_q;
  logic                    load_buf;
  logic                    gnt;
  data_t                   be_mask;
  data_t                   merged;
  data_t                   enc_data;
  data_t                   dec_data;
  codeword_t               enc_cw;
  codeword_t               inj_mask;
  logic                    bank_req;
  logic                    bank_we;
  logic [`ECC_BANK_AW-1:0] bank_addr;
  codeword_t               bank_wdata;
  codeword_t               bank_rdata;
  logic                    rd_issued_q;
  ecc_err_t                dec_err;
  ecc_err_t                err;
  ecc_inject_t             inject;
  logic                    inject_valid;
  logic                    inject_done;

  ecc_manager_regs i_regs (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .apb_req_i      (apb_req_i),
    .apb_rsp_o      (apb_rsp_o),
    .err_i          (err),
    .inject_done_i  (inject_done),
    .inject_o       (inject),
    .inject_valid_o (inject_valid)
  );

  assign req_word = tcdm_req_i.addr[`ECC_BANK_AW+1:2];  // Byte to word address

  // Merge new bytes over the corrected old word
  assign be_mask = {{8{be_q[3]}}, {8{be_q[2]}}, {8{be_q[1]}}, {8{be_q[0]}}};
  assign merged  = (be_mask & wdata_q) | (~be_mask & dec_data);

  always_comb begin
    state_d   = state_q;
    gnt       = 1'b1;
    load_buf  = 1'b0;
    bank_req  = tcdm_req_i.req;
    bank_we   = tcdm_req_i.we;
    bank_addr = req_word;
    enc_data  = tcdm_req_i.wdata;
    case (state_q)
      NORMAL: begin
        if (tcdm_req_i.req && tcdm_req_i.we && (tcdm_req_i.be != 4'b1111)) begin
          state_d  = LOAD_AND_STORE;
          bank_we  = 1'b0;  // Load the old word first
          load_buf = 1'b1;
        end
      end
      LOAD_AND_STORE: begin
        state_d   = NORMAL;
        gnt       = 1'b0;   // Core holds its next request
        bank_req  = 1'b1;
        bank_we   = 1'b1;
        bank_addr = addr_q;
        enc_data  = merged;
      end
      default: state_d = NORMAL;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= NORMAL;
      rd_issued_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      rd_issued_q <= bank_req & ~bank_we;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load_buf) begin
      addr_q  <= req_word;
      wdata_q <= tcdm_req_i.wdata;
      be_q    <= tcdm_req_i.be;
    end
  end

  secded_39_32_enc i_enc (
    .data_i (enc_data),
    .cw_o   (enc_cw)
  );

  // Flip the selected codeword bits, positions past 38 are ignored
  always_comb begin
    inj_mask = '0;
    if (inject.en_a && (inject.pos_a < 6'd39)) begin
      inj_mask |= codeword_t'(1) << inject.pos_a;
    end
    if (inject.en_b && (inject.pos_b < 6'd39)) begin
      inj_mask |= codeword_t'(1) << inject.pos_b;
    end
  end

  assign bank_wdata  = enc_cw ^ inj_mask;
  assign inject_done = bank_req & bank_we & inject_valid;

  ecc_sram_bank i_bank (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .req_i   (bank_req),
    .we_i    (bank_we),
    .addr_i  (bank_addr),
    .wdata_i (bank_wdata),
    .rdata_o (bank_rdata)
  );

  secded_39_32_dec i_dec (
    .cw_i   (bank_rdata),
    .data_o (dec_data),
    .err_o  (dec_err)
  );

  // Only a fresh read drives the counters
  assign err.single_err = rd_issued_q & dec_err.single_err;
  assign err.double_err = rd_issued_q & dec_err.double_err;

  assign tcdm_rsp_o.gnt   = gnt;
  assign tcdm_rsp_o.rdata = dec_data;

  a_gnt_single_stall: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !tcdm_rsp_o.gnt |=> tcdm_rsp_o.gnt);

  a_lns_after_write: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == LOAD_AND_STORE) |->
      $past(tcdm_req_i.req && tcdm_req_i.we && (state_q == NORMAL)));

endmodule

// File: rtl/secded_39_32_dec.sv
`timescale 1ns/10ps

module secded_39_32_dec import ecc_sram_pkg::*; (
  input  codeword_t cw_i,
  output data_t     data_o,
  output ecc_err_t  err_o
);

  localparam hsiao_cols_t h_cols = hsiao_columns();

  logic [6:0] syndrome;
  logic       synd_odd;

  // Recompute the check bits and compare with the stored ones
  always_comb begin
    syndrome = cw_i[38:32];
    for (int i = 0; i < 32; i++) begin
      syndrome ^= h_cols[i] & {7{cw_i[i]}};
    end
  end

  assign synd_odd = ^syndrome;

  // All data columns have odd weight, so a match is always a single error
  always_comb begin
    data_o = cw_i[31:0];
    for (int i = 0; i < 32; i++) begin
      if (syndrome == h_cols[i]) begin
        data_o[i] = ~cw_i[i];
      end
    end
  end

  // Odd syndrome without a data match points at a check bit
  // Data passes unchanged in that case
  assign err_o.single_err = synd_odd;
  assign err_o.double_err = (syndrome != '0) && !synd_odd;  // Even weight

endmodule

// File: rtl/secded_39_32_enc.sv
`timescale 1ns/10ps

module secded_39_32_enc import ecc_sram_pkg::*; (
  input  data_t     data_i,
  output codeword_t cw_o
);

  localparam hsiao_cols_t h_cols = hsiao_columns();

  logic [6:0] check;

  // Each data bit toggles the check bits named by its column,
  // so check[j] is the parity of data_i under row mask j
  always_comb begin
    check = '0;
    for (int i = 0; i < 32; i++) begin
      check ^= h_cols[i] & {7{data_i[i]}};
    end
  end

  assign cw_o = {check, data_i};  // Zero data encodes to an all-zero word

endmodule

// File: sim/tb_ecc_sram_top.sv
`timescale 1ns/10ps
`include "ecc_sram_config.svh"

module tb_ecc_sram_top import ecc_sram_pkg::*; ();

  typedef enum logic [1:0] {OP_TRD, OP_TWR, OP_ARD, OP_AWR} op_e;

  typedef struct packed {
    op_e         op;
    logic [3:0]  test;
    logic [31:0] addr;     // Byte address or APB offset
    data_t       data;
    logic [3:0]  be;
    logic [31:0] exp;
    logic        exp_err;  // Expected pslverr
    logic        chk;      // Compare read data
  } entry_t;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  tcdm_req_t tcdm_req;
  tcdm_rsp_t tcdm_rsp;
  apb_req_t  apb_req;
  apb_rsp_t  apb_rsp;

  entry_t      table_q[$];
  data_t       model_mem [256];
  int          fault_bits [256];   // Flipped bits stored per word
  logic [31:0] corr_cnt;
  logic [31:0] uncorr_cnt;
  logic [31:0] inj_val;            // Model of the injection register
  logic [3:0]  cur_test;
  integer      seed;
  int          error_count = 0;
  int          n_pass = 0;
  int          n_fail = 0;
  int          cycle_cnt = 0;
  int          cycle_limit = 1000;

  ecc_sram_top i_dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .tcdm_req_i (tcdm_req),
    .tcdm_rsp_o (tcdm_rsp),
    .apb_req_i  (apb_req),
    .apb_rsp_o  (apb_rsp)
  );

  always #50 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt > cycle_limit) begin
      $display("timeout: the table did not finish within %0d cycles", cycle_limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  function automatic data_t merge_bytes(data_t old_w, data_t new_w, logic [3:0] be);
    data_t res;
    res = old_w;
    for (int b = 0; b < 4; b++) begin
      if (be[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // Bits that the next bank write will flip
  function automatic int injected_bits();
    int n;
    n = 0;
    if (inj_val[6] && (inj_val[5:0] < 6'd39)) n++;
    if (inj_val[14] && (inj_val[13:8] < 6'd39)) n++;
    return n;
  endfunction

  task automatic count_fault(input logic [7:0] word);
    if (fault_bits[word] == 1) begin
      corr_cnt++;
    end else if (fault_bits[word] == 2) begin
      uncorr_cnt++;
    end
  endtask

  task automatic add_write(input logic [7:0] word, input data_t data, input logic [3:0] be);
    entry_t e;
    if (be != 4'hf) count_fault(word);  // Load phase of read-modify-write
    model_mem[word]  = merge_bytes(model_mem[word], data, be);
    fault_bits[word] = injected_bits();
    inj_val          = inj_val & 32'h3f3f;  // One-shot
    e = '{op: OP_TWR, test: cur_test, addr: {22'b0, word, 2'b00}, data: data, be: be,
          exp: '0, exp_err: 1'b0, chk: 1'b0};
    table_q.push_back(e);
  endtask

  task automatic add_read(input logic [7:0] word);
    entry_t e;
    count_fault(word);
    e = '{op: OP_TRD, test: cur_test, addr: {22'b0, word, 2'b00}, data: '0, be: '0,
          exp: model_mem[word], exp_err: 1'b0, chk: (fault_bits[word] < 2)};
    table_q.push_back(e);
  endtask

  task automatic add_apb(input op_e op, input logic [11:0] off, input logic [31:0] data);
    entry_t e;
    e = '{op: op, test: cur_test, addr: {20'b0, off}, data: data, be: '0,
          exp: '0, exp_err: 1'b0, chk: 1'b1};
    case (off)
      `ECC_REG_CORR: begin
        e.exp = corr_cnt;
        if (op == OP_AWR) corr_cnt = '0;
      end
      `ECC_REG_UNCORR: begin
        e.exp = uncorr_cnt;
        if (op == OP_AWR) uncorr_cnt = '0;
      end
      `ECC_REG_INJECT: begin
        e.exp = inj_val;
        if (op == OP_AWR) inj_val = data & 32'h7f7f;
      end
      default: e.exp_err = 1'b1;
    endcase
    table_q.push_back(e);
  endtask

  task automatic build_table();
    logic [3:0] pats [5];
    pats = '{4'b0001, 4'b0110, 4'b1000, 4'b0000, 4'b1010};
    for (int i = 0; i < 256; i++) begin
      model_mem[i]  = '0;
      fault_bits[i] = 0;
    end
    corr_cnt   = '0;
    uncorr_cnt = '0;
    inj_val    = '0;
    cur_test   = 4'd1;
    for (int i = 0; i < 4; i++) begin
      add_write(8'(i * 5 + 1), $random(seed), 4'hf);
      add_read(8'(i * 5 + 1));
    end
    add_apb(OP_ARD, `ECC_REG_CORR, '0);
    add_apb(OP_ARD, `ECC_REG_UNCORR, '0);
    cur_test = 4'd2;
    for (int i = 0; i < 5; i++) begin
      add_write(8'(40 + i), $random(seed), 4'hf);
      add_write(8'(40 + i), $random(seed), pats[i]);
      add_read(8'(40 + i));
    end
    cur_test = 4'd3;
    add_apb(OP_AWR, `ECC_REG_INJECT, 32'h0000_0045);  // Data bit 5
    add_write(8'd60, $random(seed), 4'hf);
    add_read(8'd60);
    add_read(8'd60);                                   // Fault stays stored
    add_apb(OP_ARD, `ECC_REG_CORR, '0);
    cur_test = 4'd4;
    add_apb(OP_AWR, `ECC_REG_INJECT, 32'h0000_6343);  // Bits 3 and 35
    add_write(8'd70, $random(seed), 4'hf);
    add_read(8'd70);
    add_apb(OP_ARD, `ECC_REG_UNCORR, '0);
    cur_test = 4'd5;
    add_apb(OP_ARD, `ECC_REG_INJECT, '0);
    add_apb(OP_AWR, `ECC_REG_CORR, 32'hdead_beef);
    add_apb(OP_ARD, `ECC_REG_CORR, '0);
    add_apb(OP_AWR, `ECC_REG_UNCORR, 32'h0000_1234);
    add_apb(OP_ARD, `ECC_REG_UNCORR, '0);
    add_apb(OP_ARD, 12'h00c, '0);
    add_apb(OP_AWR, 12'h010, 32'h1);
    cur_test = 4'd6;
    add_apb(OP_AWR, `ECC_REG_INJECT, 32'h0000_0054);  // Data bit 20, a kept byte
    add_write(8'd80, $random(seed), 4'hf);
    add_write(8'd80, $random(seed), 4'b0011);         // Load corrects bit 20
    add_read(8'd80);
    add_apb(OP_ARD, `ECC_REG_CORR, '0);
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (act !== exp) begin
      error_count++;
      $display("error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_reg(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      error_count++;
      $display("error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_gnt(input logic exp, input logic act);
    if (act !== exp) begin
      error_count++;
      $display("error: gnt expected %h actual %h", exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      error_count++;
      $display("error: %s expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic tcdm_access(input entry_t e);
    logic partial;
    partial = (e.be != 4'hf);
    @(negedge clk_i);
    apb_req        = '0;
    tcdm_req.req   = 1'b1;
    tcdm_req.we    = (e.op == OP_TWR);
    tcdm_req.addr  = e.addr;
    tcdm_req.wdata = e.data;
    tcdm_req.be    = e.be;
    #1;
    while (!tcdm_rsp.gnt) begin  // Hold until granted
      @(negedge clk_i);
      #1;
    end
    @(negedge clk_i);
    tcdm_req = '0;
    #1;
    if (e.op == OP_TRD) begin
      if (e.chk) check_data("rdata", e.exp, tcdm_rsp.rdata);
    end else begin
      check_gnt(!partial, tcdm_rsp.gnt);
      if (partial) begin
        @(negedge clk_i);
        #1;
        check_gnt(1'b1, tcdm_rsp.gnt);
      end
    end
  endtask

  task automatic apb_access(input entry_t e);
    @(negedge clk_i);
    tcdm_req        = '0;
    apb_req.psel    = 1'b1;      // Setup phase
    apb_req.penable = 1'b0;
    apb_req.pwrite  = (e.op == OP_AWR);
    apb_req.paddr   = e.addr[11:0];
    apb_req.pwdata  = e.data;
    @(negedge clk_i);
    apb_req.penable = 1'b1;      // Access phase
    #1;
    if (e.op == OP_ARD) check_reg("prdata", e.exp, apb_rsp.prdata);
    check_flag("pslverr", e.exp_err, apb_rsp.pslverr);
    check_flag("pready", 1'b1, apb_rsp.pready);  // Zero wait states
  endtask

  initial begin
    entry_t e;
    int     errs_before;
    seed     = 49722;
    rst_ni   = 1'b0;
    tcdm_req = '0;
    apb_req  = '0;
    build_table();
    cycle_limit = table_q.size() * 4 + 100;
    repeat (10) @(negedge clk_i);
    rst_ni = 1'b1;
    for (int k = 0; k < table_q.size(); k++) begin
      e           = table_q[k];
      errs_before = error_count;
      if ((e.op == OP_TRD) || (e.op == OP_TWR)) begin
        tcdm_access(e);
      end else begin
        apb_access(e);
      end
      if (error_count == errs_before) begin
        n_pass++;
        $display("test %0d step %0d %s ok", e.test, k, e.op.name());
      end else begin
        n_fail++;
        $display("test %0d step %0d %s failed", e.test, k, e.op.name());
      end
    end
    @(negedge clk_i);
    apb_req  = '0;
    tcdm_req = '0;
    $display("passed %0d failed %0d", n_pass, n_fail);
    if ((n_fail == 0) && (error_count == 0)) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
